// File: redmule_lite.f
logic/redmule_pkg.sv
logic/redmule_ctrl.sv
logic/redmule_scheduler.sv
logic/redmule_streamer.sv
logic/redmule_engine.sv
logic/redmule_top.sv
sim/tb_redmule_mem.sv
sim/tb_redmule.sv

// File: sim/tb_redmule.sv
// Testbench top with clock, reset and host register driver
// Three jobs, periph and event timing checks, closing report
`timescale 1ns/100ps

module tb_redmule
  import redmule_pkg::*;
();

  localparam int job_cnt = 3;
  localparam int max_k   = 15;
  // About 8 cycles per memory operation, the rest is register traffic
  localparam int max_cycles = job_cnt * (8 + 3 * max_k) * 8 + 728;

  logic              clk;
  logic              arst_n;
  logic              periph_req;
  logic              periph_we;
  reg_idx_e          periph_add;
  logic [word_w-1:0] periph_data;
  logic              periph_gnt;
  logic [word_w-1:0] periph_r_data;
  logic              periph_r_valid;
  logic              mem_req;
  logic              mem_we;
  logic [addr_w-1:0] mem_addr;
  logic [word_w-1:0] mem_wdata;
  logic              mem_gnt;
  logic [word_w-1:0] mem_rdata;
  logic              mem_rvalid;
  logic              busy;
  logic              evt;
  logic              fault;

  logic [word_w-1:0] shadow [7];
  logic [word_w-1:0] rd_expect;
  logic              job_active;
  logic [addr_w-1:0] job_x;
  logic [addr_w-1:0] job_w;
  logic [addr_w-1:0] job_y;
  logic [addr_w-1:0] job_z;
  logic [k_w-1:0]    job_k;
  int                errors;
  int                mem_errors;
  int                z_writes;
  int                jobs_done;
  int                cycles;

  redmule_top #(
    .use_redundancy_p ( 1'b1 )
  ) i_dut (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .periph_req_i     ( periph_req     ),
    .periph_we_i      ( periph_we      ),
    .periph_add_i     ( periph_add     ),
    .periph_data_i    ( periph_data    ),
    .periph_gnt_o     ( periph_gnt     ),
    .periph_r_data_o  ( periph_r_data  ),
    .periph_r_valid_o ( periph_r_valid ),
    .mem_req_o        ( mem_req        ),
    .mem_we_o         ( mem_we         ),
    .mem_addr_o       ( mem_addr       ),
    .mem_wdata_o      ( mem_wdata      ),
    .mem_gnt_i        ( mem_gnt        ),
    .mem_rdata_i      ( mem_rdata      ),
    .mem_rvalid_i     ( mem_rvalid     ),
    .busy_o           ( busy           ),
    .evt_o            ( evt            ),
    .fault_o          ( fault          )
  );

  tb_redmule_mem i_mem (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .mem_req_i    ( mem_req    ),
    .mem_we_i     ( mem_we     ),
    .mem_addr_i   ( mem_addr   ),
    .mem_wdata_i  ( mem_wdata  ),
    .mem_gnt_o    ( mem_gnt    ),
    .mem_rdata_o  ( mem_rdata  ),
    .mem_rvalid_o ( mem_rvalid ),
    .busy_i       ( busy       ),
    .evt_i        ( evt        ),
    .x_base_i     ( job_x      ),
    .w_base_i     ( job_w      ),
    .y_base_i     ( job_y      ),
    .z_base_i     ( job_z      ),
    .k_i          ( job_k      ),
    .errors_o     ( mem_errors ),
    .z_writes_o   ( z_writes   )
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (evt) jobs_done++;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles with %0d jobs finished", cycles, jobs_done);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic reg_write(input reg_idx_e add, input logic [word_w-1:0] data);
    @(negedge clk);
    // Register file ignores writes while a job runs
    if (!job_active) shadow[add] = data;
    if (add == REG_TRIGGER) job_active = 1'b1;
    periph_req  = 1'b1;
    periph_we   = 1'b1;
    periph_add  = add;
    periph_data = data;
    @(negedge clk);
    periph_req = 1'b0;
    periph_we  = 1'b0;
  endtask

  task automatic reg_read(input reg_idx_e add);
    @(negedge clk);
    // Status is read only while idle and fault stays low
    rd_expect  = (add == REG_STATUS) ? '0 : shadow[add];
    periph_req = 1'b1;
    periph_we  = 1'b0;
    periph_add = add;
    @(negedge clk);
    periph_req = 1'b0;
  endtask

  task automatic run_job(input int job, input logic [k_w-1:0] k);
    job_x = addr_w'(64 * job);
    job_w = addr_w'(64 * job + 16);
    job_y = addr_w'(64 * job + 32);
    job_z = addr_w'(64 * job + 40);
    job_k = k;
    reg_write(REG_X_BASE, word_w'(job_x));
    reg_write(REG_W_BASE, word_w'(job_w));
    reg_write(REG_Y_BASE, word_w'(job_y));
    reg_write(REG_Z_BASE, word_w'(job_z));
    reg_write(REG_K_SIZE, word_w'(job_k));
    reg_read(REG_X_BASE);
    reg_read(REG_W_BASE);
    reg_read(REG_Y_BASE);
    reg_read(REG_Z_BASE);
    reg_read(REG_K_SIZE);
    reg_write(REG_TRIGGER, word_w'(1));
    // Both land while busy and must leave the job and Z base untouched
    reg_write(REG_TRIGGER, word_w'(1));
    reg_write(REG_Z_BASE, word_w'(16'hbeef));
    while (!evt) @(negedge clk);
    job_active = 1'b0;
    @(negedge clk);
    reg_read(REG_Z_BASE);
    reg_read(REG_STATUS);
  endtask

  initial begin
    void'($urandom(94118));
    clk         = 1'b0;
    arst_n      = 1'b0;
    periph_req  = 1'b0;
    periph_we   = 1'b0;
    periph_add  = REG_X_BASE;
    periph_data = '0;
    rd_expect   = '0;
    job_active  = 1'b0;
    job_x       = '0;
    job_w       = '0;
    job_y       = '0;
    job_z       = '0;
    job_k       = '0;
    errors      = 0;
    jobs_done   = 0;
    cycles      = 0;
    for (int i = 0; i < 7; i++) shadow[i] = '0;
    i_mem.load_random();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    reg_read(REG_STATUS);
    run_job(0, k_w'(1));
    run_job(1, k_w'(max_k));
    run_job(2, k_w'($urandom_range(14, 2)));
    repeat (4) @(negedge clk);
    $display("Report: %0d jobs, %0d Z writes, %0d periph errors, %0d memory errors",
             jobs_done, z_writes, errors, mem_errors);
    if (errors + mem_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  a_gnt: assert property (@(posedge clk) disable iff (!arst_n)
    periph_gnt == periph_req)
    else begin
      errors++;
      $display("CHECK FAILED periph_gnt_o expected %h actual %h",
               $sampled(periph_req), $sampled(periph_gnt));
    end

  a_read_timing: assert property (@(posedge clk) disable iff (!arst_n)
    periph_req && !periph_we |=> periph_r_valid)
    else begin
      errors++;
      $display("Register read got no response one cycle after its grant");
    end

  a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
    periph_r_valid |-> periph_r_data == rd_expect)
    else begin
      errors++;
      $display("CHECK FAILED periph_r_data_o expected %h actual %h",
               $sampled(rd_expect), $sampled(periph_r_data));
    end

  a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
    periph_req && periph_we && periph_add == REG_TRIGGER && !busy |=> busy)
    else begin
      errors++;
      $display("busy_o did not rise the cycle after the trigger grant");
    end

  a_busy_cause: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(busy) |-> $past(periph_req && periph_we && periph_add == REG_TRIGGER))
    else begin
      errors++;
      $display("busy_o rose without a trigger write");
    end

  a_evt_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    evt |=> !evt)
    else begin
      errors++;
      $display("evt_o stayed high for more than one cycle");
    end

  a_evt_busy: assert property (@(posedge clk) disable iff (!arst_n)
    evt == $fell(busy))
    else begin
      errors++;
      $display("evt_o and the falling edge of busy_o are not in the same cycle");
    end

  a_no_fault: assert property (@(posedge clk) disable iff (!arst_n)
    !fault)
    else begin
      errors++;
      $display("CHECK FAILED fault_o expected 0 actual %h", $sampled(fault));
    end

endmodule

// File: sim/tb_redmule_mem.sv
// Memory model with random grant and read latency
// Reference Z computation and checking assertions on the memory port
`timescale 1ns/100ps

module tb_redmule_mem
  import redmule_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              mem_req_i,
  input  logic              mem_we_i,
  input  logic [addr_w-1:0] mem_addr_i,
  input  logic [word_w-1:0] mem_wdata_i,
  output logic              mem_gnt_o,
  output logic [word_w-1:0] mem_rdata_o,
  output logic              mem_rvalid_o,
  input  logic              busy_i,
  input  logic              evt_i,
  input  logic [addr_w-1:0] x_base_i,
  input  logic [addr_w-1:0] w_base_i,
  input  logic [addr_w-1:0] y_base_i,
  input  logic [addr_w-1:0] z_base_i,
  input  logic [k_w-1:0]    k_i,
  output int                errors_o,
  output int                z_writes_o
);

  localparam int depth = 256;

  logic [word_w-1:0] mem [depth];
  logic [addr_w-1:0] rd_addr;
  logic              rd_pend;
  logic              z_wr;
  int                gnt_wait;
  int                rv_wait;
  int                z_cnt;

  initial errors_o = 0;

  assign z_wr = mem_req_i & mem_gnt_o & mem_we_i;

  task automatic load_random();
    for (int a = 0; a < depth; a++) mem[a] = {$urandom, $urandom};
    mem_gnt_o    = 1'b0;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
  endtask

  // Z[r][j] = Y[r][j] + sum over k of X[r][k] * W[k][j], all modulo 2^16
  function automatic logic [word_w-1:0] expected_z_row(input int r);
    logic [word_w-1:0] row;
    logic [elem_w-1:0] sum;
    for (int j = 0; j < array_dim; j++) begin
      sum = mem[y_base_i + r][j*elem_w +: elem_w];
      for (int k = 0; k < k_i; k++) begin
        sum += mem[x_base_i + k][r*elem_w +: elem_w] *
               mem[w_base_i + k][j*elem_w +: elem_w];
      end
      row[j*elem_w +: elem_w] = sum;
    end
    return row;
  endfunction

  function automatic bit in_read_range(input logic [addr_w-1:0] a);
    return (a >= x_base_i && a < x_base_i + k_i) ||
           (a >= w_base_i && a < w_base_i + k_i) ||
           (a >= y_base_i && a < y_base_i + array_dim);
  endfunction

  // Grant after 0 to 3 cycles, read data 0 to 3 cycles after the grant
  always @(negedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_gnt_o    = 1'b0;
      mem_rvalid_o = 1'b0;
      rd_pend      = 1'b0;
      gnt_wait     = 0;
      rv_wait      = 0;
    end else begin
      mem_gnt_o    = 1'b0;
      mem_rvalid_o = 1'b0;
      if (rd_pend) begin
        rv_wait--;
        if (rv_wait == 0) begin
          mem_rvalid_o = 1'b1;
          mem_rdata_o  = mem[rd_addr];
          rd_pend      = 1'b0;
        end
      end else if (mem_req_i) begin
        if (gnt_wait > 0) begin
          gnt_wait--;
        end else begin
          mem_gnt_o = 1'b1;
          gnt_wait  = $urandom_range(3, 0);
          rd_addr   = mem_addr_i;
          if (mem_we_i) begin
            mem[mem_addr_i] = mem_wdata_i;
          end else begin
            rv_wait = $urandom_range(3, 0);
            rd_pend = (rv_wait != 0);
            if (!rd_pend) begin
              mem_rvalid_o = 1'b1;
              mem_rdata_o  = mem[mem_addr_i];
            end
          end
        end
      end
    end
  end

  // Z rows written so far in the current job
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      z_cnt      <= 0;
      z_writes_o <= 0;
    end else if (evt_i) begin
      z_cnt <= 0;
    end else if (z_wr) begin
      z_cnt      <= z_cnt + 1;
      z_writes_o <= z_writes_o + 1;
    end
  end

  a_z_addr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    z_wr |-> mem_addr_i == addr_w'(z_base_i + addr_w'(z_cnt)))
    else begin
      errors_o++;
      $display("CHECK FAILED mem_addr_o expected %h actual %h",
               addr_w'($sampled(z_base_i) + $sampled(z_cnt)), $sampled(mem_addr_i));
    end

  a_z_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    z_wr |-> mem_wdata_i == expected_z_row(z_cnt))
    else begin
      errors_o++;
      $display("CHECK FAILED mem_wdata_o expected %h actual %h",
               expected_z_row($sampled(z_cnt)), $sampled(mem_wdata_i));
    end

  a_z_extra: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    z_wr |-> z_cnt < array_dim)
    else begin
      errors_o++;
      $display("More than four Z writes in one job");
    end

  a_z_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    evt_i |-> z_cnt == array_dim)
    else begin
      errors_o++;
      $display("CHECK FAILED z write count expected %h actual %h",
               array_dim, $sampled(z_cnt));
    end

  a_rd_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_i && !mem_we_i |-> in_read_range(mem_addr_i))
    else begin
      errors_o++;
      $display("Read address %h lies outside X, W and Y of the current job",
               $sampled(mem_addr_i));
    end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_i && !mem_gnt_o |=> mem_req_i && $stable(mem_addr_i) && $stable(mem_we_i))
    else begin
      errors_o++;
      $display("Memory request dropped or changed before its grant");
    end

  a_req_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_i |-> busy_i)
    else begin
      errors_o++;
      $display("Memory request issued while no job is running");
    end

endmodule

// File: logic/redmule_top.sv
// Accelerator top level with ctrl, scheduler, streamer and engine
// Optional scheduler replica with output comparison
`timescale 1ns/100ps

module redmule_top
  import redmule_pkg::*;
#(
  parameter bit use_redundancy_p = 1'b1
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              periph_req_i,
  input  logic              periph_we_i,
  input  reg_idx_e          periph_add_i,
  input  logic [word_w-1:0] periph_data_i,
  output logic              periph_gnt_o,
  output logic [word_w-1:0] periph_r_data_o,
  output logic              periph_r_valid_o,
  output logic              mem_req_o,
  output logic              mem_we_o,
  output logic [addr_w-1:0] mem_addr_o,
  output logic [word_w-1:0] mem_wdata_o,
  input  logic              mem_gnt_i,
  input  logic [word_w-1:0] mem_rdata_i,
  input  logic              mem_rvalid_i,
  output logic              busy_o,
  output logic              evt_o,
  output logic              fault_o
);

  logic              start;
  logic [k_w-1:0]    k_size;
  logic [addr_w-1:0] x_base;
  logic [addr_w-1:0] w_base;
  logic [addr_w-1:0] y_base;
  logic [addr_w-1:0] z_base;
  logic              mismatch;

  mem_op_e           mem_op;
  logic [k_w-1:0]    index;
  logic              clear;
  logic              mac;
  logic              done;

  logic              op_done;
  logic [word_w-1:0] rdata;
  logic              rvalid;
  logic [word_w-1:0] z_row;

  redmule_ctrl i_ctrl (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .periph_req_i     ( periph_req_i     ),
    .periph_we_i      ( periph_we_i      ),
    .periph_add_i     ( periph_add_i     ),
    .periph_data_i    ( periph_data_i    ),
    .periph_gnt_o     ( periph_gnt_o     ),
    .periph_r_data_o  ( periph_r_data_o  ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .sched_done_i     ( done             ),
    .mismatch_i       ( mismatch         ),
    .start_o          ( start            ),
    .k_size_o         ( k_size           ),
    .x_base_o         ( x_base           ),
    .w_base_o         ( w_base           ),
    .y_base_o         ( y_base           ),
    .z_base_o         ( z_base           ),
    .busy_o           ( busy_o           ),
    .evt_o            ( evt_o            ),
    .fault_o          ( fault_o          )
  );

  redmule_scheduler i_scheduler (
    .clk_i     ( clk_i    ),
    .arst_n_i  ( arst_n_i ),
    .start_i   ( start    ),
    .k_size_i  ( k_size   ),
    .op_done_i ( op_done  ),
    .mem_op_o  ( mem_op   ),
    .index_o   ( index    ),
    .clear_o   ( clear    ),
    .mac_o     ( mac      ),
    .done_o    ( done     )
  );

  if (use_redundancy_p) begin : gen_replica
    mem_op_e        mem_op_r;
    logic [k_w-1:0] index_r;
    logic           clear_r;
    logic           mac_r;
    logic           done_r;

    // Replica sees the same inputs, only its outputs are compared
    redmule_scheduler i_scheduler_replica (
      .clk_i     ( clk_i    ),
      .arst_n_i  ( arst_n_i ),
      .start_i   ( start    ),
      .k_size_i  ( k_size   ),
      .op_done_i ( op_done  ),
      .mem_op_o  ( mem_op_r ),
      .index_o   ( index_r  ),
      .clear_o   ( clear_r  ),
      .mac_o     ( mac_r    ),
      .done_o    ( done_r   )
    );

    assign mismatch = (mem_op_r != mem_op) | (index_r != index) |
                      (clear_r != clear) | (mac_r != mac) | (done_r != done);
  end else begin : gen_no_replica
    assign mismatch = 1'b0;
  end

  redmule_streamer i_streamer (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .mem_op_i     ( mem_op       ),
    .index_i      ( index        ),
    .x_base_i     ( x_base       ),
    .w_base_i     ( w_base       ),
    .y_base_i     ( y_base       ),
    .z_base_i     ( z_base       ),
    .z_row_i      ( z_row        ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rdata_i  ( mem_rdata_i  ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_req_o    ( mem_req_o    ),
    .mem_we_o     ( mem_we_o     ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wdata_o  ( mem_wdata_o  ),
    .rdata_o      ( rdata        ),
    .rvalid_o     ( rvalid       ),
    .op_done_o    ( op_done      )
  );

  redmule_engine i_engine (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .clear_i  ( clear    ),
    .mem_op_i ( mem_op   ),
    .index_i  ( index    ),
    .rvalid_i ( rvalid   ),
    .rdata_i  ( rdata    ),
    .mac_i    ( mac      ),
    .z_row_o  ( z_row    )
  );

endmodule

// File: logic/redmule_engine.sv
// 4x4 integer accumulator array with X column and W row operand registers
// Y bias load, outer-product MAC and Z row readout
`timescale 1ns/100ps

module redmule_engine
  import redmule_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              clear_i,
  input  mem_op_e           mem_op_i,
  input  logic [k_w-1:0]    index_i,
  input  logic              rvalid_i,
  input  logic [word_w-1:0] rdata_i,
  input  logic              mac_i,
  output logic [word_w-1:0] z_row_o
);

  localparam int unsigned row_w = $clog2(array_dim);

  logic [array_dim-1:0][elem_w-1:0]                 rdata_elems;
  logic [array_dim-1:0][elem_w-1:0]                 x_q;
  logic [array_dim-1:0][elem_w-1:0]                 w_q;
  logic [array_dim-1:0][array_dim-1:0][elem_w-1:0]  acc_q;
  logic [row_w-1:0]                                 row_sel;

  // Element e of a word sits at bits 16e and up
  assign rdata_elems = rdata_i;
  assign row_sel     = index_i[row_w-1:0];

  // Operand registers, X holds a column and W a row
  always_ff @(posedge clk_i) begin
    if (rvalid_i && mem_op_i == OP_LOAD_X) begin
      x_q <= rdata_elems;
    end
    if (rvalid_i && mem_op_i == OP_LOAD_W) begin
      w_q <= rdata_elems;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (rvalid_i && mem_op_i == OP_LOAD_Y) begin
      // Bias row seeds the accumulators
      acc_q[row_sel] <= rdata_elems;
    end else if (mac_i) begin
      for (int i = 0; i < array_dim; i++) begin
        for (int j = 0; j < array_dim; j++) begin
          // Wraps modulo 2^16
          acc_q[i][j] <= acc_q[i][j] + x_q[i] * w_q[j];
        end
      end
    end
  end

  assign z_row_o = acc_q[row_sel];

endmodule

// File: logic/redmule_streamer.sv
// Memory streamer with address generation from base plus index
// Single outstanding req/gnt/r_valid transaction
`timescale 1ns/100ps

module redmule_streamer
  import redmule_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mem_op_e           mem_op_i,
  input  logic [k_w-1:0]    index_i,
  input  logic [addr_w-1:0] x_base_i,
  input  logic [addr_w-1:0] w_base_i,
  input  logic [addr_w-1:0] y_base_i,
  input  logic [addr_w-1:0] z_base_i,
  input  logic [word_w-1:0] z_row_i,
  input  logic              mem_gnt_i,
  input  logic [word_w-1:0] mem_rdata_i,
  input  logic              mem_rvalid_i,
  output logic              mem_req_o,
  output logic              mem_we_o,
  output logic [addr_w-1:0] mem_addr_o,
  output logic [word_w-1:0] mem_wdata_o,
  output logic [word_w-1:0] rdata_o,
  output logic              rvalid_o,
  output logic              op_done_o
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} strm_state_e;

  strm_state_e       state_q;
  strm_state_e       state_d;
  logic [addr_w-1:0] base;

  always_comb begin
    case (mem_op_i)
      OP_LOAD_X:  base = x_base_i;
      OP_LOAD_W:  base = w_base_i;
      OP_LOAD_Y:  base = y_base_i;
      OP_STORE_Z: base = z_base_i;
      default:    base = '0;
    endcase
  end

  assign mem_addr_o  = base + addr_w'(index_i);
  assign mem_we_o    = (mem_op_i == OP_STORE_Z);
  assign mem_wdata_o = z_row_i;
  assign mem_req_o   = (state_q == S_REQ);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: if (mem_op_i != OP_NONE) state_d = S_REQ;
      S_REQ: begin
        if (mem_gnt_i) state_d = (mem_we_o || mem_rvalid_i) ? S_IDLE : S_WAIT;
      end
      S_WAIT: if (mem_rvalid_i) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) state_q <= S_IDLE;
    else           state_q <= state_d;
  end

  // Read data is accepted in the wait state, or alongside the grant
  assign rdata_o   = mem_rdata_i;
  assign rvalid_o  = mem_rvalid_i &
                     ((state_q == S_WAIT) | (mem_req_o & mem_gnt_i & ~mem_we_o));
  assign op_done_o = rvalid_o | (mem_req_o & mem_gnt_i & mem_we_o);

  // Relies on the scheduler holding op and index until op_done
  a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o));

endmodule

// File: logic/redmule_scheduler.sv
// Job sequencing FSM over Y load, K x (X, W, MAC) and Z store
// Drives memory op, row or column index and engine strobes
`timescale 1ns/100ps

module redmule_scheduler
  import redmule_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           start_i,
  input  logic [k_w-1:0] k_size_i,
  input  logic           op_done_i,
  output mem_op_e        mem_op_o,
  output logic [k_w-1:0] index_o,
  output logic           clear_o,
  output logic           mac_o,
  output logic           done_o
);

  localparam logic [k_w-1:0] last_row = k_w'(array_dim - 1);

  sched_state_e   state_q;
  sched_state_e   state_d;
  logic [k_w-1:0] cnt_q;
  logic [k_w-1:0] cnt_d;
  logic [k_w-1:0] k_q;
  logic [k_w-1:0] last_k;

  assign last_k = k_q - 1'b1;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_LOAD_Y;
          cnt_d   = '0;
        end
      end
      ST_LOAD_Y: begin
        if (op_done_i) begin
          if (cnt_q == last_row) begin
            state_d = ST_LOAD_X;
            cnt_d   = '0;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end
      ST_LOAD_X: begin
        if (op_done_i) state_d = ST_LOAD_W;
      end
      ST_LOAD_W: begin
        if (op_done_i) state_d = ST_MAC;
      end
      ST_MAC: begin
        // One outer product per k step
        if (cnt_q == last_k) begin
          state_d = ST_STORE_Z;
          cnt_d   = '0;
        end else begin
          state_d = ST_LOAD_X;
          cnt_d   = cnt_q + 1'b1;
        end
      end
      ST_STORE_Z: begin
        if (op_done_i) begin
          if (cnt_q == last_row) begin
            state_d = ST_DONE;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      k_q     <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (state_q == ST_IDLE && start_i) begin
        k_q <= k_size_i;
      end
    end
  end

  always_comb begin
    case (state_q)
      ST_LOAD_Y:  mem_op_o = OP_LOAD_Y;
      ST_LOAD_X:  mem_op_o = OP_LOAD_X;
      ST_LOAD_W:  mem_op_o = OP_LOAD_W;
      ST_STORE_Z: mem_op_o = OP_STORE_Z;
      default:    mem_op_o = OP_NONE;
    endcase
  end

  assign index_o = cnt_q;
  assign clear_o = (state_q == ST_IDLE) & start_i;
  assign mac_o   = (state_q == ST_MAC);
  assign done_o  = (state_q == ST_DONE);

  // MAC only ever directly follows a completed W load
  a_mac_after_w: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mac_o |-> $past(state_q == ST_LOAD_W && op_done_i));

endmodule

// File: logic/redmule_ctrl.sv
// Controller with the periph register file and job start
// Busy flag, completion event and sticky fault
`timescale 1ns/100ps

module redmule_ctrl
  import redmule_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              periph_req_i,
  input  logic              periph_we_i,
  input  reg_idx_e          periph_add_i,
  input  logic [word_w-1:0] periph_data_i,
  output logic              periph_gnt_o,
  output logic [word_w-1:0] periph_r_data_o,
  output logic              periph_r_valid_o,
  input  logic              sched_done_i,
  input  logic              mismatch_i,
  output logic              start_o,
  output logic [k_w-1:0]    k_size_o,
  output logic [addr_w-1:0] x_base_o,
  output logic [addr_w-1:0] w_base_o,
  output logic [addr_w-1:0] y_base_o,
  output logic [addr_w-1:0] z_base_o,
  output logic              busy_o,
  output logic              evt_o,
  output logic              fault_o
);

  logic              wr_en;
  logic              trigger;
  logic [word_w-1:0] rd_mux;
  logic              busy_q;
  logic              start_q;
  logic              evt_q;
  logic              fault_q;

  // Grant is immediate, writes only land while idle
  assign periph_gnt_o = periph_req_i;
  assign wr_en        = periph_req_i & periph_we_i & ~busy_q;
  assign trigger      = wr_en & (periph_add_i == REG_TRIGGER);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_base_o <= '0;
      w_base_o <= '0;
      y_base_o <= '0;
      z_base_o <= '0;
      k_size_o <= '0;
    end else if (wr_en) begin
      case (periph_add_i)
        REG_X_BASE: x_base_o <= periph_data_i[addr_w-1:0];
        REG_W_BASE: w_base_o <= periph_data_i[addr_w-1:0];
        REG_Y_BASE: y_base_o <= periph_data_i[addr_w-1:0];
        REG_Z_BASE: z_base_o <= periph_data_i[addr_w-1:0];
        REG_K_SIZE: k_size_o <= periph_data_i[k_w-1:0];
        default: ;
      endcase
    end
  end

  // Job lifetime, busy drops together with the event
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      evt_q   <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      start_q <= trigger;
      evt_q   <= sched_done_i;
      fault_q <= fault_q | mismatch_i;
      if (trigger) begin
        busy_q <= 1'b1;
      end else if (sched_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (periph_add_i)
      REG_X_BASE: rd_mux = word_w'(x_base_o);
      REG_W_BASE: rd_mux = word_w'(w_base_o);
      REG_Y_BASE: rd_mux = word_w'(y_base_o);
      REG_Z_BASE: rd_mux = word_w'(z_base_o);
      REG_K_SIZE: rd_mux = word_w'(k_size_o);
      REG_STATUS: rd_mux = word_w'({fault_q, busy_q});
      default:    rd_mux = '0;
    endcase
  end

  // Read response one cycle after the grant
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      periph_r_valid_o <= 1'b0;
    end else begin
      periph_r_valid_o <= periph_req_i & ~periph_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (periph_req_i && !periph_we_i) begin
      periph_r_data_o <= rd_mux;
    end
  end

  assign start_o = start_q;
  assign busy_o  = busy_q;
  assign evt_o   = evt_q;
  assign fault_o = fault_q;

  // A new job never launches in the cycle the previous one reports completion
  a_evt_not_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(evt_o && start_o));

  a_evt_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    evt_o |=> !evt_o);

endmodule

// File: logic/redmule_pkg.sv
// Shared sizes of the matrix-multiply accelerator
// Register index, scheduler state and memory operation enums

package redmule_pkg;

  // Array and element geometry
  localparam int unsigned array_dim = 4;
  localparam int unsigned elem_w    = 16;

  // One memory or register word holds a full row of elements
  localparam int unsigned word_w = 64;
  localparam int unsigned addr_w = 16;

  // K runs from 1 to 15
  localparam int unsigned k_w = 4;

  // Host-visible registers
  typedef enum logic [2:0] {
    REG_X_BASE  = 3'd0,
    REG_W_BASE  = 3'd1,
    REG_Y_BASE  = 3'd2,
    REG_Z_BASE  = 3'd3,
    REG_K_SIZE  = 3'd4,
    REG_TRIGGER = 3'd5,
    REG_STATUS  = 3'd6   // bit 0 busy, bit 1 fault
  } reg_idx_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD_Y,
    ST_LOAD_X,
    ST_LOAD_W,
    ST_MAC,
    ST_STORE_Z,
    ST_DONE
  } sched_state_e;

  // Memory operation, also selects the engine capture target
  typedef enum logic [2:0] {
    OP_NONE,
    OP_LOAD_Y,
    OP_LOAD_X,
    OP_LOAD_W,
    OP_STORE_Z
  } mem_op_e;

endpackage
